// File: Makefile
VERILATOR  := verilator
TOP        := tb_mini_core
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -j 0 --Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
rtl/rv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
rtl/exec_unit.sv
rtl/mini_core.sv
sim/mini_core_props.sv
sim/tb_mini_core.sv

// File: rtl/core_cfg_pkg.sv
// --------------------------------------------------------------------------
// Core configuration. queue_depth of 1 or more, any value works.
// --------------------------------------------------------------------------
package core_cfg_pkg;

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // instruction queue entries
    localparam int queue_depth = 2;

    // queue pointer width, at least one bit
    localparam int queue_ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;

    // integer register file size, x0 included
    localparam int reg_count = 32;

endpackage

// File: rtl/exec_unit.sv
// --------------------------------------------------------------------------
// Executes ADD, SUB, ADDI, ANDI, ORI, XORI. Everything else retires illegal
// with rd 0 and data 0. Register write and commit share one clock edge.
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module exec_unit
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // from the instruction queue
    input  logic        pop_valid,
    input  logic [31:0] pop_data,
    output logic        pop_ready,

    // commit trace
    output logic        commit_valid,
    input  logic        commit_ready,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        commit_illegal
);

    rv_instr_u   instr;
    logic [31:0] regs [reg_count];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm_sext;
    logic [31:0] result;
    logic        illegal;
    logic        do_pop;
    logic        wr_en;

    assign instr = rv_instr_u'(pop_data);

    // output register free, or emptied by the sink this cycle
    assign pop_ready = !commit_valid || commit_ready;
    assign do_pop    = pop_valid && pop_ready;

    // ----------------------------------------------------------------------
    // operands
    // ----------------------------------------------------------------------
    // x0 is never written, so its read is forced to zero
    assign rs1_val  = (instr.r.rs1 == 5'd0) ? 32'd0 : regs[instr.r.rs1];
    assign rs2_val  = (instr.r.rs2 == 5'd0) ? 32'd0 : regs[instr.r.rs2];
    assign imm_sext = {{20{instr.i.imm[11]}}, instr.i.imm};

    // ----------------------------------------------------------------------
    // decode and ALU
    // ----------------------------------------------------------------------
    always_comb begin
        illegal = 1'b0;
        result  = 32'd0;
        case (instr.r.opcode)
            op_reg: begin
                // only ADD and SUB of the R-type group
                if (instr.r.funct3 == f3_add && instr.r.funct7 == 7'd0) begin
                    result = rs1_val + rs2_val;
                end else if (instr.r.funct3 == f3_add && instr.r.funct7 == f7_sub) begin
                    result = rs1_val - rs2_val;
                end else begin
                    illegal = 1'b1;
                end
            end
            op_imm: begin
                case (instr.i.funct3)
                    f3_add:  result = rs1_val + imm_sext;
                    f3_xor:  result = rs1_val ^ imm_sext;
                    f3_or:   result = rs1_val | imm_sext;
                    f3_and:  result = rs1_val & imm_sext;
                    default: illegal = 1'b1;
                endcase
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    assign wr_en = do_pop && !illegal && (instr.r.rd != 5'd0);

    // register file, written at the pop edge so the next word sees it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[instr.r.rd] <= result;
        end
    end

    // ----------------------------------------------------------------------
    // commit register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid   <= 1'b0;
            commit_illegal <= 1'b0;
        end else if (do_pop) begin
            commit_valid   <= 1'b1;
            commit_illegal <= illegal;
        end else if (commit_ready) begin
            commit_valid   <= 1'b0;
        end
    end

    // payload only changes on a pop, so it holds while stalled
    always_ff @(posedge clk) begin
        if (do_pop) begin
            commit_rd   <= illegal ? 5'd0 : instr.r.rd;
            // writes to x0 and illegal words report zero
            commit_data <= (illegal || instr.r.rd == 5'd0) ? 32'd0 : result;
        end
    end

endmodule

// File: rtl/fetch_unit.sv
// --------------------------------------------------------------------------
// Sequential fetch, PC only steps by 4. One request outstanding at a time.
// Relies on the queue never losing room while a request is pending.
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module fetch_unit
    import core_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // instruction memory, request/grant
    output logic        instr_req,
    output logic [31:0] instr_addr,
    input  logic        instr_gnt,
    input  logic [31:0] instr_data,

    // towards the instruction queue
    output logic        push_valid,
    output logic [31:0] push_data,
    input  logic        push_ready
);

    logic [31:0] pc;
    logic        req_pending;
    logic        granted;

    // request completes in the grant cycle
    assign granted = req_pending & instr_gnt;

    // ----------------------------------------------------------------------
    // request handling
    // ----------------------------------------------------------------------
    // raised only while the queue has room, held until granted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_pending <= 1'b0;
        end else if (granted) begin
            req_pending <= 1'b0;
        end else if (!req_pending && push_ready) begin
            req_pending <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // program counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (granted) begin
            pc <= pc + 32'd4;
        end
    end

    assign instr_req  = req_pending;
    assign instr_addr = pc;

    // granted word goes straight into the queue
    // room is guaranteed since the request was started with push_ready high
    assign push_valid = granted;
    assign push_data  = instr_data;

endmodule

// File: rtl/instr_queue.sv
// --------------------------------------------------------------------------
// Circular FIFO of queue_depth words. Accepts a push when full if a pop
// happens in the same cycle. No bypass, a pushed word pops a cycle later.
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module instr_queue
    import core_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // write side, from fetch
    input  logic        push_valid,
    input  logic [31:0] push_data,
    output logic        push_ready,

    // read side, to execute
    output logic        pop_valid,
    output logic [31:0] pop_data,
    input  logic        pop_ready
);

    localparam logic [queue_ptr_w-1:0] last_ptr = queue_ptr_w'(queue_depth - 1);

    logic [31:0]            mem [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full       = (count == (queue_ptr_w + 1)'(queue_depth));
    assign pop_valid  = (count != '0);
    assign push_ready = !full || pop_ready;
    assign pop_data   = mem[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    // storage, payload only
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ----------------------------------------------------------------------
    // pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + queue_ptr_w'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + queue_ptr_w'(1);
            end
            // simultaneous push and pop leaves count unchanged
            if (do_push && !do_pop) begin
                count <= count + (queue_ptr_w + 1)'(1);
            end else if (do_pop && !do_push) begin
                count <= count - (queue_ptr_w + 1)'(1);
            end
        end
    end

endmodule

// File: rtl/mini_core.sv
// --------------------------------------------------------------------------
// Straight-line RV32 subset core. No branches, loads, stores or traps.
// Instruction port is request/grant, commit trace is valid/ready.
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mini_core (
    input  logic        clk,
    input  logic        rst_n,

    // instruction memory
    output logic        instr_req,
    output logic [31:0] instr_addr,
    input  logic        instr_gnt,
    input  logic [31:0] instr_data,

    // commit trace
    output logic        commit_valid,
    input  logic        commit_ready,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        commit_illegal
);

    // fetch to queue
    logic        push_valid;
    logic [31:0] push_data;
    logic        push_ready;

    // queue to execute
    logic        pop_valid;
    logic [31:0] pop_data;
    logic        pop_ready;

    fetch_unit i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_req  (instr_req),
        .instr_addr (instr_addr),
        .instr_gnt  (instr_gnt),
        .instr_data (instr_data),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready)
    );

    instr_queue i_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .pop_ready  (pop_ready)
    );

    exec_unit i_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .pop_valid      (pop_valid),
        .pop_data       (pop_data),
        .pop_ready      (pop_ready),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

endmodule

// File: rtl/rv_isa_pkg.sv
// --------------------------------------------------------------------------
// RV32I encodings for the integer subset that this core executes.
// Only the register and immediate ALU forms are described.
// --------------------------------------------------------------------------
package rv_isa_pkg;

    // ----------------------------------------------------------------------
    // major opcodes
    // ----------------------------------------------------------------------
    // register-register ALU group
    localparam logic [6:0] op_reg = 7'b0110011;
    // register-immediate ALU group
    localparam logic [6:0] op_imm = 7'b0010011;

    // ----------------------------------------------------------------------
    // function codes
    // ----------------------------------------------------------------------
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 of SUB, ADD uses all zeros
    localparam logic [6:0] f7_sub = 7'b0100000;

    // ----------------------------------------------------------------------
    // instruction word
    // ----------------------------------------------------------------------
    // same 32 bits seen either as R-type or as I-type
    // rs1, funct3, rd and opcode sit at the same place in both views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            // sign bit is imm[11]
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } rv_instr_u;

endpackage

// File: sim/core_stim.txt
// columns: program word, expected commit_rd, expected commit_data, illegal flag
// all hex, one instruction per line in program order
00100093 01 00000001 0   // addi x1, x0, 1
001080b3 01 00000002 0   // add  x1, x1, x1
001080b3 01 00000004 0   // add  x1, x1, x1
001080b3 01 00000008 0   // add  x1, x1, x1
001080b3 01 00000010 0   // add  x1, x1, x1
001080b3 01 00000020 0   // add  x1, x1, x1
00100113 02 00000001 0   // addi x2, x0, 1
00100193 03 00000001 0   // addi x3, x0, 1
00310233 04 00000002 0   // add  x4, x2, x3
00418133 02 00000003 0   // add  x2, x3, x4
002201b3 03 00000005 0   // add  x3, x4, x2
00310233 04 00000008 0   // add  x4, x2, x3
404102b3 05 fffffffb 0   // sub  x5, x2, x4
fff2c313 06 00000004 0   // xori x6, x5, -1
ff036393 07 fffffff4 0   // ori  x7, x6, -16
f003f413 08 ffffff00 0   // andi x8, x7, -256
00508013 00 00000000 0   // addi x0, x1, 5
000004b3 09 00000000 0   // add  x9, x0, x0
021080b3 00 00000000 1   // mul  x1, x1, x1 (unsupported)
00008513 0a 00000020 0   // addi x10, x1, 0
004505b3 0b 00000028 0   // add  x11, x10, x4

// File: sim/mini_core_props.sv
// --------------------------------------------------------------------------
// Port rules of mini_core. All but the reset rule are off while rst_n is low.
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mini_core_props (
    input logic        clk,
    input logic        rst_n,
    input logic        instr_req,
    input logic [31:0] instr_addr,
    input logic        instr_gnt,
    input logic        commit_valid,
    input logic        commit_ready,
    input logic [4:0]  commit_rd,
    input logic [31:0] commit_data,
    input logic        commit_illegal
);

    int fail_count = 0;

    // request and address held until the grant cycle
    req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_req && !instr_gnt |=> instr_req && $stable(instr_addr)
    ) else begin
        fail_count++;
        $error("instr_req or instr_addr changed before the grant");
    end

    // stalled commit keeps all its outputs
    commit_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_rd)
            && $stable(commit_data) && $stable(commit_illegal)
    ) else begin
        fail_count++;
        $error("commit outputs changed while stalled");
    end

    reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !instr_req && !commit_valid
    ) else begin
        fail_count++;
        $error("instr_req or commit_valid high during reset");
    end

endmodule

// File: sim/tb_mini_core.sv
// --------------------------------------------------------------------------
// Run from the project root, program and expected commits come from
// sim/core_stim.txt. Memory grants only inside the program, never past it.
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_mini_core
    import rv_isa_pkg::*;
();

    logic        clk          = 1'b0;
    logic        rst_n        = 1'b1;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        instr_gnt    = 1'b0;
    logic [31:0] instr_data   = 32'd0;
    logic        commit_valid;
    logic        commit_ready = 1'b0;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_illegal;

    // one entry per program line
    logic [31:0] prog_word [$];
    logic [31:0] exp_rd    [$];
    logic [31:0] exp_data  [$];
    logic [31:0] exp_ill   [$];

    int prog_len    = 0;
    int cycle_limit = 100;
    int cycle_count = 0;
    int commit_idx  = 0;
    int req_age     = 0;
    int gnt_delay   = 0;

    mini_core i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req      (instr_req),
        .instr_addr     (instr_addr),
        .instr_gnt      (instr_gnt),
        .instr_data     (instr_data),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

    bind mini_core mini_core_props i_props (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req      (instr_req),
        .instr_addr     (instr_addr),
        .instr_gnt      (instr_gnt),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual,
                     expected);
            $display("TESTS FAILED");
            $fatal(1, "%s differs from the expected value", name);
        end
    endtask

    // rows are word, rd, data, illegal; comment lines do not scan
    task automatic load_program();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] word;
        logic [31:0] rd;
        logic [31:0] data;
        logic [31:0] ill;
        rv_instr_u   dec;
        fd = $fopen("sim/core_stim.txt", "r");
        if (fd == 0) begin
            $display("TESTS FAILED");
            $fatal(1, "could not open sim/core_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %h", word, rd, data, ill);
                if (fields == 4) begin
                    dec = rv_instr_u'(word);
                    // legal rows must name the rd field of their own word
                    if (ill == 32'd0) begin
                        check_value("stim rd field", 32'(dec.r.rd), rd);
                    end
                    prog_word.push_back(word);
                    exp_rd.push_back(rd);
                    exp_data.push_back(data);
                    exp_ill.push_back(ill);
                end
            end
            $fclose(fd);
            prog_len = prog_word.size();
        end
    endtask

    // ----------------------------------------------------------------------
    // instruction memory, grant 1 to 3 cycles after the request is seen
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : mem_model
        int delay_now;
        int word_idx;
        if (!rst_n) begin
            instr_gnt <= 1'b0;
            req_age   <= 0;
        end else if (instr_gnt) begin
            instr_gnt <= 1'b0;
            req_age   <= 0;
        end else if (instr_req) begin
            check_value("instr_addr[1:0]", 32'(instr_addr[1:0]), 32'd0);
            delay_now = (req_age == 0) ? int'($urandom % 3) + 1 : gnt_delay;
            word_idx  = int'(instr_addr >> 2);
            gnt_delay <= delay_now;
            req_age   <= req_age + 1;
            if (req_age + 1 >= delay_now && word_idx < prog_len) begin
                instr_gnt  <= 1'b1;
                instr_data <= prog_word[word_idx];
            end
        end
    end

    // trace sink, ready about one cycle in four so the queue fills up
    always @(posedge clk) begin
        if (!rst_n) begin
            commit_ready <= 1'b0;
        end else begin
            commit_ready <= ($urandom % 4) == 0;
        end
    end

    // ----------------------------------------------------------------------
    // commit monitor and run limit
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("TESTS FAILED");
                $fatal(1, "timeout after %0d cycles, %0d of %0d instructions committed",
                       cycle_count, commit_idx, prog_len);
            end else if (i_dut.i_props.fail_count != 0) begin
                $display("TESTS FAILED");
                $fatal(1, "a protocol assertion on the DUT ports failed");
            end else if (commit_valid && commit_ready) begin
                if (commit_idx >= prog_len) begin
                    $display("TESTS FAILED");
                    $fatal(1, "commit seen after the last program instruction");
                end else begin
                    check_value("commit_rd", 32'(commit_rd), exp_rd[commit_idx]);
                    check_value("commit_data", commit_data, exp_data[commit_idx]);
                    check_value("commit_illegal", 32'(commit_illegal), exp_ill[commit_idx]);
                    commit_idx = commit_idx + 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hb3f374bc));
        // falling edge at time zero starts the asynchronous reset
        rst_n <= 1'b0;
        load_program();
        cycle_limit = 20 * prog_len + 100;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait (commit_idx == prog_len);
        // quiet window, no further commit may show up
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (prog_len > 0 && commit_idx == prog_len && i_dut.i_props.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "committed %0d instructions for %0d program lines", commit_idx,
                   prog_len);
        end
    end

endmodule
